//--- cbm2_sys_pkg.sv
// ====================
// Machine description for the CBM-II loader path.
// Holds the system selection, the model and RAM-size codes and the
// main-RAM address width. Import where the machine is decoded.
// ====================

package cbm2_sys_pkg;

	// Menu selection of the system
	typedef enum logic [2:0] {
		P500,
		B610,
		B620,
		B710,
		B720,
		CUSTOM
	} sys_sel_e;

	// 0 is the P500 line, 1 the B series
	typedef enum logic {
		PROFESSIONAL,
		BUSINESS
	} model_e;

	typedef enum logic [1:0] {
		RAM_128K,
		RAM_256K,
		RAM_896K
	} ram_size_e;

	// Byte address into main RAM
	localparam int MEM_ADDR_W = 25;

endpackage

//--- cbm2_load_pkg.sv
// ====================
// Download description for the CBM-II loader path.
// Download kinds, byte width, BASIC pointer locations and the
// SID filter table limits.
// ====================

package cbm2_load_pkg;

	typedef enum logic [1:0] {
		OTHER,
		PRG,
		FLT
	} dl_kind_e;

	localparam int DL_INDEX_W = 6;
	localparam int DATA_W     = 8;

	// Filter table of 3072 words at two download bytes per word
	localparam int FLT_WORDS  = 3072;
	localparam int FLT_ADDR_W = 12;

	// Zero page of bank 15 holds the BASIC pointers
	localparam int INJ_BASE = 'hF0000;

	localparam logic [7:0] TXTTAB_LO = 8'h2D;
	localparam logic [7:0] TXTTAB_HI = 8'h2E;
	localparam logic [7:0] TXTEND_LO = 8'h2F;
	localparam logic [7:0] TXTEND_HI = 8'h30;

	// Map a download index onto its kind
	function automatic dl_kind_e dl_kind(input logic [DL_INDEX_W-1:0] index);
		case (index)
			6'd14: return PRG;
			6'd15: return FLT;
			default: return OTHER;
		endcase
	endfunction

endpackage

//--- mem_wr_if.sv
// ====================
// One byte write into main RAM under valid/ready.
// The source holds valid, addr and data until ready is seen.
// ====================

`timescale 1ns/1ns

interface mem_wr_if #(
	parameter int ADDR_W = cbm2_sys_pkg::MEM_ADDR_W
) ();

	import cbm2_load_pkg::*;

	logic              valid;
	logic              ready;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;

	modport src (
		output valid,
		output addr,
		output data,
		input  ready
	);

	modport sink (
		input  valid,
		input  addr,
		input  data,
		output ready
	);

endinterface

//--- cbm2_sys_config.sv
// ====================
// Decodes the system selection into machine model and RAM size.
// Both results are registered, one cycle behind the inputs.
// ====================

`timescale 1ns/1ns

module cbm2_sys_config (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  cbm2_sys_pkg::sys_sel_e   sys_sel_i,
	input  logic [1:0]               custom_model_i,
	input  cbm2_sys_pkg::ram_size_e  custom_ram_i,
	output cbm2_sys_pkg::model_e     model_o,
	output cbm2_sys_pkg::ram_size_e  ram_size_o
);

	import cbm2_sys_pkg::*;

	model_e    model_d;
	ram_size_e ram_size_d;

	always_comb begin
		model_d    = (sys_sel_i == P500) ? PROFESSIONAL : BUSINESS;
		ram_size_d = RAM_128K;
		case (sys_sel_i)
			B620, B720: ram_size_d = RAM_256K;
			CUSTOM: begin
				// Either custom model bit selects a business machine
				model_d    = (|custom_model_i) ? BUSINESS : PROFESSIONAL;
				ram_size_d = custom_ram_i;
			end
			default: ram_size_d = RAM_128K;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			model_o    <= PROFESSIONAL;
			ram_size_o <= RAM_128K;
		end else begin
			model_o    <= model_d;
			ram_size_o <= ram_size_d;
		end
	end

endmodule

//--- prg_loader.sv
// ====================
// PRG download into main RAM.
// Takes the load address from the first two bytes, writes the rest
// one byte per handshake, then sets the BASIC text pointers.
// ====================

`timescale 1ns/1ns

module prg_loader #(
	parameter int ADDR_W = cbm2_sys_pkg::MEM_ADDR_W
) (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	input  logic                                   dl_active_i,
	input  logic                                   dl_valid_i,
	input  logic [cbm2_load_pkg::DL_INDEX_W-1:0]   dl_index_i,
	input  logic [cbm2_sys_pkg::MEM_ADDR_W-1:0]    dl_addr_i,
	input  logic [cbm2_load_pkg::DATA_W-1:0]       dl_data_i,
	input  cbm2_sys_pkg::model_e                   model_i,
	input  logic                                   erase_busy_i,
	output logic                                   dl_ready_o,
	mem_wr_if.src                                  wr
);

	import cbm2_sys_pkg::*;
	import cbm2_load_pkg::*;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_WRITE,
		INJ_WRITE,
		INJ_NEXT
	} load_state_e;

	load_state_e       state_q;
	load_state_e       state_d;
	logic              rdy_q;
	logic              active_q;
	logic              prg_seen_q;
	logic              inj_pend_q;
	logic              inj_pend_d;
	logic [1:0]        inj_sel_q;
	logic [ADDR_W-1:0] load_addr_q;
	logic [DATA_W-1:0] data_q;
	logic [DATA_W-1:0] inj_byte;
	logic [7:0]        inj_off;
	logic [15:0]       start_ptr_q;
	logic [15:0]       end_ptr_q;
	logic              accept;
	logic              is_prg;
	logic              data_byte;
	logic              hs;
	logic              dl_fall;

	assign accept    = dl_valid_i & dl_ready_o;
	assign is_prg    = (dl_kind(dl_index_i) == PRG);
	assign data_byte = accept & is_prg & (dl_addr_i > 1);
	assign hs        = wr.valid & wr.ready;
	assign dl_fall   = active_q & ~dl_active_i;

	// Held off while a write is pending or RAM is being erased
	assign dl_ready_o = rdy_q & ~erase_busy_i;

	// ====================
	// FSM
	// ====================
	always_comb begin
		state_d    = state_q;
		inj_pend_d = inj_pend_q | (dl_fall & prg_seen_q);
		case (state_q)
			LOAD_IDLE: begin
				if (data_byte) begin
					state_d = LOAD_WRITE;
				end else if (inj_pend_q) begin
					state_d    = INJ_WRITE;
					inj_pend_d = 1'b0;
				end
			end
			LOAD_WRITE: if (hs) state_d = LOAD_IDLE;
			INJ_WRITE:  if (hs) state_d = INJ_NEXT;
			INJ_NEXT:   state_d = (inj_sel_q == 2'd3) ? LOAD_IDLE : INJ_WRITE;
			default:    state_d = LOAD_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state_q    <= LOAD_IDLE;
			rdy_q      <= 1'b0;
			active_q   <= 1'b0;
			prg_seen_q <= 1'b0;
			inj_pend_q <= 1'b0;
			inj_sel_q  <= 2'd0;
		end else begin
			state_q    <= state_d;
			rdy_q      <= (state_d == LOAD_IDLE) && !inj_pend_d;
			active_q   <= dl_active_i;
			inj_pend_q <= inj_pend_d;
			if (accept && is_prg)
				prg_seen_q <= 1'b1;
			else if (dl_fall)
				prg_seen_q <= 1'b0;
			// Wraps back to the first pointer byte after the last one
			if (state_q == INJ_NEXT)
				inj_sel_q <= inj_sel_q + 2'd1;
		end
	end

	// Load address, data byte and BASIC pointers
	always_ff @(posedge clk_sys) begin
		if (accept && is_prg) begin
			if (dl_addr_i == 0) begin
				load_addr_q[7:0]          <= dl_data_i;
				load_addr_q[ADDR_W-1:16]  <= (ADDR_W-16)'(model_i == BUSINESS);
				start_ptr_q[7:0]          <= dl_data_i;
				end_ptr_q[7:0]            <= dl_data_i;
			end else if (dl_addr_i == 1) begin
				load_addr_q[15:8] <= dl_data_i;
				start_ptr_q[15:8] <= dl_data_i;
				end_ptr_q[15:8]   <= dl_data_i;
			end else begin
				data_q    <= dl_data_i;
				end_ptr_q <= end_ptr_q + 16'd1;
			end
		end
		if (state_q == LOAD_WRITE && hs)
			load_addr_q <= load_addr_q + 1'b1;
	end

	// Pointer byte order TXTTAB then TXTEND
	always_comb begin
		case (inj_sel_q)
			2'd0: begin
				inj_off  = TXTTAB_LO;
				inj_byte = start_ptr_q[7:0];
			end
			2'd1: begin
				inj_off  = TXTTAB_HI;
				inj_byte = start_ptr_q[15:8];
			end
			2'd2: begin
				inj_off  = TXTEND_LO;
				inj_byte = end_ptr_q[7:0];
			end
			default: begin
				inj_off  = TXTEND_HI;
				inj_byte = end_ptr_q[15:8];
			end
		endcase
	end

	assign wr.valid = (state_q == LOAD_WRITE) || (state_q == INJ_WRITE);
	assign wr.addr  = (state_q == INJ_WRITE) ? ADDR_W'(INJ_BASE) + ADDR_W'(inj_off)
	                                         : load_addr_q;
	assign wr.data  = (state_q == INJ_WRITE) ? inj_byte : data_q;

endmodule

//--- ram_eraser.sv
// ====================
// Fills main RAM with the power-on pattern.
// A start pulse latches the range for the current machine, then
// one write is issued per handshake up to the end address.
// ====================

`timescale 1ns/1ns

module ram_eraser #(
	parameter int ADDR_W = cbm2_sys_pkg::MEM_ADDR_W
) (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     erase_start_i,
	input  cbm2_sys_pkg::model_e     model_i,
	input  cbm2_sys_pkg::ram_size_e  ram_size_i,
	output logic                     erase_busy_o,
	mem_wr_if.src                    wr
);

	import cbm2_sys_pkg::*;
	import cbm2_load_pkg::*;

	typedef enum logic {
		ERASE_IDLE,
		ERASE_RUN
	} erase_state_e;

	erase_state_e      state_q;
	logic [ADDR_W-1:0] addr_q;
	logic [ADDR_W-1:0] end_addr_q;
	logic [ADDR_W-1:0] start_d;
	logic [ADDR_W-1:0] end_d;
	logic              hs;

	// Business machines keep bank 0 out of user RAM
	always_comb begin
		start_d = (model_i == BUSINESS) ? ADDR_W'(20'h10000) : '0;
		case (ram_size_i)
			RAM_128K: end_d = (model_i == BUSINESS) ? ADDR_W'(20'h2FFFF) : ADDR_W'(20'h1FFFF);
			RAM_256K: end_d = (model_i == BUSINESS) ? ADDR_W'(20'h4FFFF) : ADDR_W'(20'h3FFFF);
			default:  end_d = ADDR_W'(20'hEFFFF);
		endcase
	end

	assign hs = wr.valid & wr.ready;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state_q <= ERASE_IDLE;
		end else begin
			case (state_q)
				ERASE_IDLE: if (erase_start_i) state_q <= ERASE_RUN;
				ERASE_RUN:  if (hs && addr_q == end_addr_q) state_q <= ERASE_IDLE;
				default:    state_q <= ERASE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state_q == ERASE_IDLE && erase_start_i) begin
			addr_q     <= start_d;
			end_addr_q <= end_d;
		end else if (hs) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	assign erase_busy_o = (state_q == ERASE_RUN);
	assign wr.valid     = (state_q == ERASE_RUN);
	assign wr.addr      = addr_q;
	// Striped pattern as left by the real DRAM at power-on
	assign wr.data      = {DATA_W{addr_q[14] ^ addr_q[3] ^ addr_q[2]}};

endmodule

//--- mem_write_arbiter.sv
// ====================
// Merges the eraser and loader writes onto the external port.
// Eraser wins when both ask; a stalled write keeps its grant.
// ====================

`timescale 1ns/1ns

module mem_write_arbiter #(
	parameter int ADDR_W = cbm2_sys_pkg::MEM_ADDR_W
) (
	input  logic                              clk_sys,
	input  logic                              RESET,
	mem_wr_if.sink                            erase_wr,
	mem_wr_if.sink                            load_wr,
	output logic                              mem_valid_o,
	input  logic                              mem_ready_i,
	output logic [ADDR_W-1:0]                 mem_addr_o,
	output logic [cbm2_load_pkg::DATA_W-1:0]  mem_data_o
);

	logic locked_q;
	logic owner_erase_q;
	logic sel_erase;

	// Locked grant follows the stalled source, else eraser priority
	assign sel_erase = locked_q ? owner_erase_q : erase_wr.valid;

	assign mem_valid_o = sel_erase ? erase_wr.valid : load_wr.valid;
	assign mem_addr_o  = sel_erase ? erase_wr.addr  : load_wr.addr;
	assign mem_data_o  = sel_erase ? erase_wr.data  : load_wr.data;

	assign erase_wr.ready = sel_erase & mem_ready_i;
	assign load_wr.ready  = ~sel_erase & mem_ready_i;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			locked_q      <= 1'b0;
			owner_erase_q <= 1'b0;
		end else if (mem_valid_o && !mem_ready_i) begin
			locked_q      <= 1'b1;
			owner_erase_q <= sel_erase;
		end else begin
			locked_q <= 1'b0;
		end
	end

endmodule

//--- sid_filter_loader.sv
// ====================
// Builds SID filter table words from the FLT download.
// Even byte is the low half, odd byte completes the word.
// ====================

`timescale 1ns/1ns

module sid_filter_loader (
	input  logic                                  clk_sys,
	input  logic                                  RESET,
	input  logic                                  dl_valid_i,
	input  logic [cbm2_load_pkg::DL_INDEX_W-1:0]  dl_index_i,
	input  logic [cbm2_sys_pkg::MEM_ADDR_W-1:0]   dl_addr_i,
	input  logic [cbm2_load_pkg::DATA_W-1:0]      dl_data_i,
	output logic                                  flt_wr_o,
	output logic [cbm2_load_pkg::FLT_ADDR_W-1:0]  flt_addr_o,
	output logic [15:0]                           flt_data_o
);

	import cbm2_load_pkg::*;

	logic take;

	// Bytes past the end of the table are dropped
	assign take = dl_valid_i && (dl_kind(dl_index_i) == FLT) && (dl_addr_i < 2 * FLT_WORDS);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			flt_wr_o <= 1'b0;
		else
			flt_wr_o <= take & dl_addr_i[0];
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (dl_addr_i[0]) begin
				flt_data_o[15:8] <= dl_data_i;
				flt_addr_o       <= dl_addr_i[FLT_ADDR_W:1];
			end else begin
				flt_data_o[7:0] <= dl_data_i;
			end
		end
	end

endmodule

//--- cbm2_loader_top.sv
// ====================
// Download and RAM-init path of the CBM-II core.
// Connects config decode, eraser, PRG and filter loaders and
// the write arbiter. All main-RAM writes leave on mem_*.
// ====================

`timescale 1ns/1ns

module cbm2_loader_top #(
	parameter int ADDR_W = cbm2_sys_pkg::MEM_ADDR_W
) (
	input  logic                                  clk_sys,
	input  logic                                  RESET,

	// Download stream
	input  logic                                  dl_active_i,
	input  logic                                  dl_valid_i,
	input  logic [cbm2_load_pkg::DL_INDEX_W-1:0]  dl_index_i,
	input  logic [cbm2_sys_pkg::MEM_ADDR_W-1:0]   dl_addr_i,
	input  logic [cbm2_load_pkg::DATA_W-1:0]      dl_data_i,
	output logic                                  dl_ready_o,

	// Main RAM write port
	output logic                                  mem_valid_o,
	input  logic                                  mem_ready_i,
	output logic [ADDR_W-1:0]                     mem_addr_o,
	output logic [cbm2_load_pkg::DATA_W-1:0]      mem_data_o,

	// SID filter table
	output logic                                  flt_wr_o,
	output logic [cbm2_load_pkg::FLT_ADDR_W-1:0]  flt_addr_o,
	output logic [15:0]                           flt_data_o,

	// Machine configuration
	input  cbm2_sys_pkg::sys_sel_e                sys_sel_i,
	input  logic [1:0]                            custom_model_i,
	input  cbm2_sys_pkg::ram_size_e               custom_ram_i,
	output cbm2_sys_pkg::model_e                  model_o,
	output cbm2_sys_pkg::ram_size_e               ram_size_o,

	input  logic                                  erase_start_i,
	output logic                                  erase_busy_o
);

	logic dl_accept;

	mem_wr_if #(.ADDR_W(ADDR_W)) erase_wr ();
	mem_wr_if #(.ADDR_W(ADDR_W)) load_wr ();

	// Filter bytes count only when the stream handshake completes
	assign dl_accept = dl_valid_i & dl_ready_o;

	cbm2_sys_config cbm2_sys_config_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.sys_sel_i      (sys_sel_i),
		.custom_model_i (custom_model_i),
		.custom_ram_i   (custom_ram_i),
		.model_o        (model_o),
		.ram_size_o     (ram_size_o)
	);

	ram_eraser #(.ADDR_W(ADDR_W)) ram_eraser_inst (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.erase_start_i (erase_start_i),
		.model_i       (model_o),
		.ram_size_i    (ram_size_o),
		.erase_busy_o  (erase_busy_o),
		.wr            (erase_wr.src)
	);

	prg_loader #(.ADDR_W(ADDR_W)) prg_loader_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_active_i  (dl_active_i),
		.dl_valid_i   (dl_valid_i),
		.dl_index_i   (dl_index_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.model_i      (model_o),
		.erase_busy_i (erase_busy_o),
		.dl_ready_o   (dl_ready_o),
		.wr           (load_wr.src)
	);

	mem_write_arbiter #(.ADDR_W(ADDR_W)) mem_write_arbiter_inst (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.erase_wr    (erase_wr.sink),
		.load_wr     (load_wr.sink),
		.mem_valid_o (mem_valid_o),
		.mem_ready_i (mem_ready_i),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

	sid_filter_loader sid_filter_loader_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_valid_i (dl_accept),
		.dl_index_i (dl_index_i),
		.dl_addr_i  (dl_addr_i),
		.dl_data_i  (dl_data_i),
		.flt_wr_o   (flt_wr_o),
		.flt_addr_o (flt_addr_o),
		.flt_data_o (flt_data_o)
	);

endmodule

//--- tb_cbm2_loader_vectors.svh
// ====================
// Test table for the CBM-II loader testbench.
// One row per test, applied in order by the main loop.
// Included inside the testbench module after the package imports.
// ====================

`ifndef TB_CBM2_LOADER_VECTORS_SVH
`define TB_CBM2_LOADER_VECTORS_SVH

typedef enum logic [1:0] {
	OP_ERASE,
	OP_PRG,
	OP_FLT
} test_op_e;

typedef struct packed {
	test_op_e    op;
	sys_sel_e    sel;
	logic [1:0]  cmodel;
	ram_size_e   cram;
	// PRG load address and length, or filter byte count
	int unsigned load_addr;
	int unsigned length;
	model_e      exp_model;
	ram_size_e   exp_ram;
	// Main-RAM addresses, or table indexes for a filter download
	int unsigned exp_first;
	int unsigned exp_last;
	int unsigned exp_count;
} test_row_t;

localparam int NUM_TESTS = 11;

test_row_t tests [NUM_TESTS];

task automatic fill_test_table();
	// Erase rows for each model and RAM size
	tests[0]  = '{OP_ERASE, P500, 2'd0, RAM_128K, 0, 0,
	              PROFESSIONAL, RAM_128K, 'h00000, 'h1FFFF, 'h20000};
	tests[1]  = '{OP_ERASE, B610, 2'd0, RAM_128K, 0, 0,
	              BUSINESS, RAM_128K, 'h10000, 'h2FFFF, 'h20000};
	tests[2]  = '{OP_ERASE, B620, 2'd0, RAM_128K, 0, 0,
	              BUSINESS, RAM_256K, 'h10000, 'h4FFFF, 'h40000};
	tests[3]  = '{OP_ERASE, CUSTOM, 2'd0, RAM_256K, 0, 0,
	              PROFESSIONAL, RAM_256K, 'h00000, 'h3FFFF, 'h40000};
	tests[4]  = '{OP_ERASE, CUSTOM, 2'd0, RAM_896K, 0, 0,
	              PROFESSIONAL, RAM_896K, 'h00000, 'hEFFFF, 'hF0000};
	tests[5]  = '{OP_ERASE, CUSTOM, 2'd2, RAM_896K, 0, 0,
	              BUSINESS, RAM_896K, 'h10000, 'hEFFFF, 'hE0000};
	// PRG downloads count data bytes plus four pointer bytes
	tests[6]  = '{OP_PRG, B710, 2'd0, RAM_896K, 'h0400, 40,
	              BUSINESS, RAM_128K, 'h10400, 'h10427, 44};
	tests[7]  = '{OP_PRG, CUSTOM, 2'd1, RAM_128K, 'h0003, 300,
	              BUSINESS, RAM_128K, 'h10003, 'h1012E, 304};
	tests[8]  = '{OP_PRG, P500, 2'd0, RAM_128K, 'h2000, 17,
	              PROFESSIONAL, RAM_128K, 'h02000, 'h02010, 21};
	// Filter downloads end in bytes past the table or an unpaired byte
	tests[9]  = '{OP_FLT, B720, 2'd0, RAM_128K, 0, 6150,
	              BUSINESS, RAM_256K, 0, 3071, 3072};
	tests[10] = '{OP_FLT, CUSTOM, 2'd3, RAM_256K, 0, 21,
	              BUSINESS, RAM_256K, 0, 9, 10};
endtask

`endif

//--- tb_cbm2_loader.sv
// ====================
// Testbench for the CBM-II download and RAM-init path.
// Runs the test table through erase, PRG and filter downloads
// against a byte memory model with random back-pressure.
// ====================

`timescale 1ns/1ns

module tb_cbm2_loader;

	import cbm2_sys_pkg::*;
	import cbm2_load_pkg::*;

	`include "tb_cbm2_loader_vectors.svh"

	logic                  clk_sys;
	logic                  RESET;
	logic                  dl_active_i;
	logic                  dl_valid_i;
	logic [DL_INDEX_W-1:0] dl_index_i;
	logic [MEM_ADDR_W-1:0] dl_addr_i;
	logic [DATA_W-1:0]     dl_data_i;
	logic                  dl_ready_o;
	logic                  mem_valid_o;
	logic                  mem_ready_i;
	logic [MEM_ADDR_W-1:0] mem_addr_o;
	logic [DATA_W-1:0]     mem_data_o;
	logic                  flt_wr_o;
	logic [FLT_ADDR_W-1:0] flt_addr_o;
	logic [15:0]           flt_data_o;
	sys_sel_e              sys_sel_i;
	logic [1:0]            custom_model_i;
	ram_size_e             custom_ram_i;
	model_e                model_o;
	ram_size_e             ram_size_o;
	logic                  erase_start_i;
	logic                  erase_busy_o;

	// Memory model and write bookkeeping
	logic [7:0]  mem [int unsigned];
	logic [7:0]  stim_bytes [$];
	int unsigned flt_idx [$];
	int unsigned flt_word [$];
	int unsigned write_count;
	int unsigned first_addr;
	int unsigned last_addr;
	int unsigned erase_next;
	bit          erase_mode;
	int unsigned cycles;
	int unsigned cycle_limit;
	int unsigned seed;

	cbm2_loader_top #(.ADDR_W(MEM_ADDR_W)) cbm2_loader_top_inst (.*);

	always #20 clk_sys = ~clk_sys;

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got === exp)
		else stop_with_error($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Power-on fill with every bit set to addr[14] ^ addr[3] ^ addr[2]
	function automatic logic [7:0] pattern_byte(input logic [31:0] addr);
		return {8{addr[14] ^ addr[3] ^ addr[2]}};
	endfunction

	function automatic int unsigned row_cycles(input test_row_t row);
		case (row.op)
			OP_ERASE: return row.exp_count;
			OP_PRG:   return row.length + 6;
			default:  return row.length;
		endcase
	endfunction

	// Present one byte and hold it until the DUT takes it
	task automatic send_byte(input logic [5:0] index, input int unsigned addr,
	                         input logic [7:0] data);
		bit taken;
		taken      = 1'b0;
		dl_valid_i = 1'b1;
		dl_index_i = index;
		dl_addr_i  = MEM_ADDR_W'(addr);
		dl_data_i  = data;
		while (!taken) begin
			@(negedge clk_sys);
			taken = dl_ready_o;
			@(posedge clk_sys);
			#2;
		end
		dl_valid_i = 1'b0;
	endtask

	task automatic apply_config(input test_row_t row);
		sys_sel_i      = row.sel;
		custom_model_i = row.cmodel;
		custom_ram_i   = row.cram;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("model_o", model_o, row.exp_model);
		check_value("ram_size_o", ram_size_o, row.exp_ram);
		@(posedge clk_sys);
		#2;
	endtask

	task automatic erase_ram(input test_row_t row);
		erase_next    = row.exp_first;
		erase_mode    = 1'b1;
		erase_start_i = 1'b1;
		@(posedge clk_sys);
		#2;
		erase_start_i = 1'b0;
		@(negedge clk_sys);
		check_value("erase_busy_o", erase_busy_o, 1);
		while (erase_busy_o)
			@(negedge clk_sys);
		erase_mode = 1'b0;
		check_value("mem_valid_o count", write_count, row.exp_count);
		check_value("mem_addr_o first", first_addr, row.exp_first);
		check_value("mem_addr_o last", last_addr, row.exp_last);
	endtask

	task automatic load_prg(input test_row_t row);
		logic [15:0] end_ptr;
		end_ptr = row.load_addr[15:0] + row.length[15:0];
		stim_bytes.delete();
		for (int i = 0; i < row.length; i++)
			stim_bytes.push_back(8'($urandom));
		dl_active_i = 1'b1;
		send_byte(6'd14, 0, row.load_addr[7:0]);
		send_byte(6'd14, 1, row.load_addr[15:8]);
		for (int i = 0; i < row.length; i++)
			send_byte(6'd14, i + 2, stim_bytes[i]);
		dl_active_i = 1'b0;
		// Data and pointer writes done once the loader takes bytes again
		while (write_count < row.exp_count || !dl_ready_o)
			@(negedge clk_sys);
		check_value("mem_valid_o count", write_count, row.exp_count);
		check_value("mem_addr_o first", first_addr, row.exp_first);
		check_value("mem_addr_o distinct", mem.num(), row.exp_count);
		for (int i = 0; i < row.length; i++)
			check_value("mem_data_o", mem[row.exp_first + i], stim_bytes[i]);
		check_value("mem_data_o last", mem[row.exp_last], stim_bytes[row.length - 1]);
		check_value("mem_data_o txttab_lo", mem[INJ_BASE + TXTTAB_LO], row.load_addr[7:0]);
		check_value("mem_data_o txttab_hi", mem[INJ_BASE + TXTTAB_HI], row.load_addr[15:8]);
		check_value("mem_data_o txtend_lo", mem[INJ_BASE + TXTEND_LO], end_ptr[7:0]);
		check_value("mem_data_o txtend_hi", mem[INJ_BASE + TXTEND_HI], end_ptr[15:8]);
	endtask

	task automatic load_filter(input test_row_t row);
		stim_bytes.delete();
		for (int i = 0; i < row.length; i++)
			stim_bytes.push_back(8'($urandom));
		dl_active_i = 1'b1;
		for (int i = 0; i < row.length; i++)
			send_byte(6'd15, i, stim_bytes[i]);
		dl_active_i = 1'b0;
		// Word strobe comes one cycle after the odd byte
		repeat (2) @(negedge clk_sys);
		check_value("flt_wr_o count", flt_idx.size(), row.exp_count);
		check_value("mem_valid_o count", write_count, 0);
		for (int k = 0; k < row.exp_count; k++) begin
			check_value("flt_addr_o", flt_idx[k], row.exp_first + k);
			check_value("flt_data_o", flt_word[k], {stim_bytes[2*k+1], stim_bytes[2*k]});
		end
		check_value("flt_addr_o last", flt_idx[flt_idx.size() - 1], row.exp_last);
	endtask

	// Back-pressure on the memory port
	always @(posedge clk_sys) begin
		#2;
		mem_ready_i = (($urandom() & 32'd3) != 0);
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
			stop_with_error($sformatf("timeout, tests not finished after %0d cycles", cycles));
	end

	// ====================
	// Write capture and checks
	// ====================
	always @(negedge clk_sys) begin
		if (!RESET) begin
			assert (!(dl_ready_o && erase_busy_o))
			else stop_with_error("dl_ready_o was high while an erase was running");
			if (mem_valid_o && mem_ready_i) begin
				if (write_count == 0)
					first_addr = mem_addr_o;
				last_addr   = mem_addr_o;
				write_count = write_count + 1;
				if (erase_mode) begin
					check_value("mem_addr_o", mem_addr_o, erase_next);
					check_value("mem_data_o", mem_data_o, pattern_byte(mem_addr_o));
					erase_next = erase_next + 1;
				end else begin
					mem[mem_addr_o] = mem_data_o;
				end
			end
			if (flt_wr_o) begin
				flt_idx.push_back(flt_addr_o);
				flt_word.push_back(flt_data_o);
			end
		end
	end

	initial begin
		seed           = $urandom(239);
		clk_sys        = 1'b0;
		RESET          = 1'b1;
		dl_active_i    = 1'b0;
		dl_valid_i     = 1'b0;
		dl_index_i     = '0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		mem_ready_i    = 1'b0;
		sys_sel_i      = P500;
		custom_model_i = 2'd0;
		custom_ram_i   = RAM_128K;
		erase_start_i  = 1'b0;
		erase_mode     = 1'b0;
		write_count    = 0;
		cycles         = 0;
		fill_test_table();
		cycle_limit = 64 * NUM_TESTS + 64;
		for (int t = 0; t < NUM_TESTS; t++)
			cycle_limit = cycle_limit + 4 * row_cycles(tests[t]);

		repeat (7) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("mem_valid_o", mem_valid_o, 0);
		check_value("flt_wr_o", flt_wr_o, 0);
		check_value("erase_busy_o", erase_busy_o, 0);
		check_value("dl_ready_o", dl_ready_o, 0);
		@(posedge clk_sys);
		#2;
		RESET = 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("dl_ready_o", dl_ready_o, 1);
		@(posedge clk_sys);
		#2;

		for (int t = 0; t < NUM_TESTS; t++) begin
			write_count = 0;
			mem.delete();
			flt_idx.delete();
			flt_word.delete();
			apply_config(tests[t]);
			case (tests[t].op)
				OP_ERASE: erase_ram(tests[t]);
				OP_PRG:   load_prg(tests[t]);
				default:  load_filter(tests[t]);
			endcase
			@(posedge clk_sys);
			#2;
		end

		$display("sim passed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+.
cbm2_sys_pkg.sv
cbm2_load_pkg.sv
mem_wr_if.sv
cbm2_sys_config.sv
prg_loader.sv
ram_eraser.sv
mem_write_arbiter.sv
sid_filter_loader.sv
cbm2_loader_top.sv
tb_cbm2_loader.sv

//--- Makefile
# Verilator build and run of the CBM-II loader testbench

VERILATOR ?= verilator
TOP       ?= tb_cbm2_loader
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
